/* rv_pkg.sv */
// shared widths, opcode/alu/state enums, decoded instruction and bus request structs
package rv_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int num_regs   = 32;
    localparam int strb_w     = xlen / 8;

    localparam logic [xlen-1:0]   instr_bytes = 32'd4; // pc step
    localparam logic [strb_w-1:0] word_strobe = '1;    // all byte lanes

    // rv32i major opcodes, op_nop stands in for anything unknown
    typedef enum logic [6:0] {
        op_nop    = 7'b0000000,
        op_load   = 7'b0000011,
        op_imm    = 7'b0010011,
        op_auipc  = 7'b0010111,
        op_store  = 7'b0100011,
        op_reg    = 7'b0110011,
        op_lui    = 7'b0110111,
        op_branch = 7'b1100011,
        op_jalr   = 7'b1100111,
        op_jal    = 7'b1101111
    } opcode_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_op_t;

    typedef enum logic [2:0] {
        st_fetch,
        st_decode,
        st_execute,
        st_mem,
        st_writeback
    } ctrl_state_t;

    typedef struct packed {
        opcode_t               op;
        alu_op_t               alu_op;
        logic [2:0]            funct3;
        logic [reg_addr_w-1:0] rd;
        logic [reg_addr_w-1:0] rs1;
        logic [reg_addr_w-1:0] rs2;
        logic [xlen-1:0]       imm;     // sign extended
        logic                  use_imm; // operand b from imm
    } decoded_t;

    typedef struct packed {
        logic            read;
        logic [xlen-1:0] addr;
    } imem_req_t;

    typedef struct packed {
        logic              read;
        logic [strb_w-1:0] write; // byte strobe, zero when idle
        logic [xlen-1:0]   addr;
        logic [xlen-1:0]   wdata;
    } dmem_req_t;

endpackage

/* rv_regfile.sv */
// 32 x 32 register file, two async read ports, one write port, x0 fixed at zero
`timescale 1ns/10ps

module rv_regfile
    import rv_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic [reg_addr_w-1:0] rs1,
    input  logic [reg_addr_w-1:0] rs2,
    output logic [xlen-1:0]       rs1_data,
    output logic [xlen-1:0]       rs2_data,
    input  logic                  we,
    input  logic [reg_addr_w-1:0] rd,
    input  logic [xlen-1:0]       wdata
);

    logic [xlen-1:0] regs [num_regs];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin // x0 writes dropped
            regs[rd] <= wdata;
        end
    end

    assign rs1_data = regs[rs1];
    assign rs2_data = regs[rs2];

    assert property (@(posedge clk) disable iff (rst)
        ((rs1 == '0) |-> (rs1_data == '0)) and ((rs2 == '0) |-> (rs2_data == '0)));

endmodule

/* rv_alu.sv */
// alu with operand select and branch condition evaluation
`timescale 1ns/10ps

module rv_alu
    import rv_pkg::*;
(
    input  decoded_t        dec,
    input  logic [xlen-1:0] rs1_data,
    input  logic [xlen-1:0] rs2_data,
    input  logic [xlen-1:0] pc,
    output logic [xlen-1:0] result,
    output logic            branch_taken
);

    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b;
    logic [4:0]      shamt;
    logic            cond;

    assign op_a  = (dec.op == op_auipc) ? pc : rs1_data;
    assign op_b  = dec.use_imm ? dec.imm : rs2_data;
    assign shamt = op_b[4:0];

    always_comb begin
        case (dec.alu_op)
            alu_add:  result = op_a + op_b;
            alu_sub:  result = op_a - op_b;
            alu_sll:  result = op_a << shamt;
            alu_slt:  result = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            alu_sltu: result = {{(xlen-1){1'b0}}, op_a < op_b};
            alu_xor:  result = op_a ^ op_b;
            alu_srl:  result = op_a >> shamt;
            alu_sra:  result = $unsigned($signed(op_a) >>> shamt);
            alu_or:   result = op_a | op_b;
            alu_and:  result = op_a & op_b;
            default:  result = '0;
        endcase
    end

    // branches always compare the two registers
    always_comb begin
        case (dec.funct3)
            3'b000:  cond = (rs1_data == rs2_data);
            3'b001:  cond = (rs1_data != rs2_data);
            3'b100:  cond = ($signed(rs1_data) < $signed(rs2_data));
            3'b101:  cond = ($signed(rs1_data) >= $signed(rs2_data));
            3'b110:  cond = (rs1_data < rs2_data);
            3'b111:  cond = (rs1_data >= rs2_data);
            default: cond = 1'b0;
        endcase
    end

    assign branch_taken = (dec.op == op_branch) && cond;

endmodule

/* rv_decode.sv */
// instruction register, opcode classification, field extraction and immediates
`timescale 1ns/10ps

module rv_decode
    import rv_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic            load,
    input  logic [xlen-1:0] instr,
    output decoded_t        dec
);

    decoded_t        nxt;
    opcode_t         opc;
    logic [xlen-1:0] i_imm;
    logic [xlen-1:0] s_imm;
    logic [xlen-1:0] b_imm;
    logic [xlen-1:0] u_imm;
    logic [xlen-1:0] j_imm;

    function automatic alu_op_t alu_sel(input logic [2:0] f3, input logic alt,
                                        input logic is_reg);
        case (f3)
            3'b000:  return (is_reg && alt) ? alu_sub : alu_add; // no subi
            3'b001:  return alu_sll;
            3'b010:  return alu_slt;
            3'b011:  return alu_sltu;
            3'b100:  return alu_xor;
            3'b101:  return alt ? alu_sra : alu_srl;
            3'b110:  return alu_or;
            default: return alu_and;
        endcase
    endfunction

    assign opc   = opcode_t'(instr[6:0]);
    assign i_imm = {{20{instr[31]}}, instr[31:20]};
    assign s_imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign b_imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign u_imm = {instr[31:12], 12'b0};
    assign j_imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        nxt         = '0;
        nxt.op      = opc;
        nxt.alu_op  = alu_add;
        nxt.funct3  = instr[14:12];
        nxt.rd      = instr[11:7];
        nxt.rs1     = instr[19:15];
        nxt.rs2     = instr[24:20];
        case (opc)
            op_reg:    nxt.alu_op = alu_sel(instr[14:12], instr[30], 1'b1);
            op_imm: begin
                nxt.alu_op  = alu_sel(instr[14:12], instr[30], 1'b0);
                nxt.imm     = i_imm;
                nxt.use_imm = 1'b1;
            end
            op_load, op_jalr: begin
                nxt.imm     = i_imm;
                nxt.use_imm = 1'b1;
            end
            op_store: begin
                nxt.imm     = s_imm;
                nxt.use_imm = 1'b1;
            end
            op_branch: nxt.imm = b_imm;
            op_jal:    nxt.imm = j_imm;
            op_lui: begin
                nxt.imm     = u_imm;
                nxt.use_imm = 1'b1;
                nxt.rs1     = '0; // x0 + imm
            end
            op_auipc: begin
                nxt.imm     = u_imm;
                nxt.use_imm = 1'b1;
            end
            default:   nxt.op = op_nop;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dec <= '0; // op_nop
        end else if (load) begin
            dec <= nxt;
        end
    end

endmodule

/* rv_lsu.sv */
// load/store unit, registers one data-port request per memory instruction
`timescale 1ns/10ps

module rv_lsu
    import rv_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic            start,
    input  decoded_t        dec,
    input  logic [xlen-1:0] addr,
    input  logic [xlen-1:0] store_data,
    output dmem_req_t       dmem_req
);

    logic is_load;
    logic is_store;

    assign is_load  = start && (dec.op == op_load);
    assign is_store = start && (dec.op == op_store);

    always_ff @(posedge clk) begin
        if (rst) begin
            dmem_req.read  <= 1'b0;
            dmem_req.write <= '0;
        end else begin
            dmem_req.read  <= is_load;
            dmem_req.write <= is_store ? word_strobe : '0; // word access only
        end
        if (start) begin
            dmem_req.addr  <= addr;
            dmem_req.wdata <= store_data;
        end
    end

    // single-cycle request, never read and write at once
    assert property (@(posedge clk) disable iff (rst)
        (dmem_req.read || dmem_req.write != '0) |->
            !(dmem_req.read && dmem_req.write != '0) ##1
            (!dmem_req.read && dmem_req.write == '0));

endmodule

/* rv_control.sv */
// control FSM: state sequencing, pc, fetch request, next-pc and writeback select
`timescale 1ns/10ps

module rv_control
    import rv_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  decoded_t              dec,
    input  logic [xlen-1:0]       alu_result,
    input  logic                  branch_taken,
    input  logic [xlen-1:0]       rs1_data,
    input  logic [xlen-1:0]       data_rdata,
    output imem_req_t             imem_req,
    output logic                  dec_load,
    output logic                  mem_start,
    output logic                  rd_we,
    output logic [reg_addr_w-1:0] rd_addr,
    output logic [xlen-1:0]       rd_wdata
);

    ctrl_state_t     state;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] pc_plus4;
    logic [xlen-1:0] pc_next;
    logic [xlen-1:0] jalr_target;
    logic            is_mem;
    logic            is_link;
    logic            writes_rd;

    assign pc_plus4    = pc + instr_bytes;
    assign jalr_target = rs1_data + dec.imm;
    assign is_mem      = (dec.op == op_load) || (dec.op == op_store);
    assign is_link     = (dec.op == op_jal) || (dec.op == op_jalr);
    assign writes_rd   = (dec.op == op_reg) || (dec.op == op_imm) || (dec.op == op_lui) ||
                         (dec.op == op_auipc) || is_link;

    assign imem_req.read = (state == st_fetch);
    assign imem_req.addr = pc;
    assign dec_load      = (state == st_decode);
    assign mem_start     = (state == st_execute) && is_mem;
    assign rd_addr       = dec.rd;

    always_comb begin
        if (dec.op == op_jalr) begin
            pc_next = {jalr_target[xlen-1:1], 1'b0}; // low bit cleared
        end else if (branch_taken || dec.op == op_jal) begin
            pc_next = pc + dec.imm;
        end else begin
            pc_next = pc_plus4;
        end
    end

    always_comb begin
        rd_we = ((state == st_execute) && writes_rd) ||
                ((state == st_writeback) && (dec.op == op_load));
        if (dec.op == op_load) begin
            rd_wdata = data_rdata;
        end else if (is_link) begin
            rd_wdata = pc_plus4; // return address
        end else begin
            rd_wdata = alu_result;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_writeback; // idle cycle while the decoder holds a nop
            pc    <= '0;
        end else begin
            case (state)
                st_fetch:   state <= st_decode;
                st_decode:  state <= st_execute;
                st_execute: begin
                    pc    <= pc_next;
                    state <= is_mem ? st_mem : st_fetch;
                end
                st_mem:     state <= (dec.op == op_load) ? st_writeback : st_fetch;
                default:    state <= st_fetch;
            endcase
        end
    end

    // every fetch is followed by decode and a fetch-free execute
    assert property (@(posedge clk) disable iff (rst)
        imem_req.read |=> dec_load ##1 !imem_req.read);

    // a register write closes the instruction
    assert property (@(posedge clk) disable iff (rst)
        rd_we |=> state == st_fetch);

endmodule

/* rv_core.sv */
// rv32i multi-cycle core top: sequencer, decoder, register file, alu and load/store unit
`timescale 1ns/10ps

module rv_core
    import rv_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    output imem_req_t       imem_req,
    input  logic [xlen-1:0] instr_rdata,
    output dmem_req_t       dmem_req,
    input  logic [xlen-1:0] data_rdata
);

    decoded_t              dec;
    logic                  dec_load;
    logic                  mem_start;
    logic                  rd_we;
    logic [reg_addr_w-1:0] rd_addr;
    logic [xlen-1:0]       rd_wdata;
    logic [xlen-1:0]       rs1_data;
    logic [xlen-1:0]       rs2_data;
    logic [xlen-1:0]       alu_result;
    logic                  branch_taken;

    rv_control control_i (
        .clk          (clk),
        .rst          (rst),
        .dec          (dec),
        .alu_result   (alu_result),
        .branch_taken (branch_taken),
        .rs1_data     (rs1_data),
        .data_rdata   (data_rdata),
        .imem_req     (imem_req),
        .dec_load     (dec_load),
        .mem_start    (mem_start),
        .rd_we        (rd_we),
        .rd_addr      (rd_addr),
        .rd_wdata     (rd_wdata)
    );

    rv_decode decode_i (
        .clk   (clk),
        .rst   (rst),
        .load  (dec_load),
        .instr (instr_rdata),
        .dec   (dec)
    );

    rv_regfile regfile_i (
        .clk      (clk),
        .rst      (rst),
        .rs1      (dec.rs1),
        .rs2      (dec.rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .we       (rd_we),
        .rd       (rd_addr),
        .wdata    (rd_wdata)
    );

    // fetch address doubles as the current pc
    rv_alu alu_i (
        .dec          (dec),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .pc           (imem_req.addr),
        .result       (alu_result),
        .branch_taken (branch_taken)
    );

    rv_lsu lsu_i (
        .clk        (clk),
        .rst        (rst),
        .start      (mem_start),
        .dec        (dec),
        .addr       (alu_result),
        .store_data (rs2_data),
        .dmem_req   (dmem_req)
    );

endmodule

/* rv_checker.sv */
// instruction-set model of the rv32i subset, fetch address and data request checks
`timescale 1ns/10ps

module rv_checker
    import rv_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  imem_req_t imem_req,
    input  dmem_req_t dmem_req,
    output int        errors,
    output int        pending
);

    logic [xlen-1:0] prog [int];
    logic [xlen-1:0] mdata [int];
    logic [xlen-1:0] regs [num_regs];
    logic [xlen-1:0] pc;
    dmem_req_t       exp_q [$]; // data requests in program order
    logic            rst_d;
    int              reqs_since_fetch;

    task automatic load_word(input int idx, input logic [xlen-1:0] word);
        prog[idx] = word;
    endtask

    task automatic reset_model();
        pc = '0;
        for (int i = 0; i < num_regs; i++) begin
            regs[i] = '0;
        end
        mdata.delete();
        exp_q.delete();
        reqs_since_fetch = 0;
    endtask

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] want);
        if (got !== want) begin
            $display("CHECK FAILED %s got %h expected %h at %0t", name, got, want, $time);
            errors++;
        end
    endtask

    function automatic logic [xlen-1:0] alu_model(input logic [2:0] f3, input logic alt,
                                                  input logic [xlen-1:0] a,
                                                  input logic [xlen-1:0] b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  return (a < b) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101:  return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    // executes the instruction at the model pc
    task automatic step_model();
        logic [xlen-1:0] ins;
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        logic [xlen-1:0] imm_i;
        logic [xlen-1:0] ea;
        logic [xlen-1:0] res;
        logic [xlen-1:0] nxt;
        logic            wr;
        logic            take;
        ins   = prog.exists(int'(pc[xlen-1:2])) ? prog[int'(pc[xlen-1:2])] : '0;
        a     = regs[ins[19:15]];
        b     = regs[ins[24:20]];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        nxt   = pc + 32'd4;
        res   = '0;
        wr    = 1'b1;
        take  = 1'b0;
        case (ins[6:0])
            op_reg:   res = alu_model(ins[14:12], ins[30], a, b);
            op_imm:   res = alu_model(ins[14:12], ins[30] && ins[14:12] == 3'b101, a, imm_i);
            op_lui:   res = {ins[31:12], 12'b0};
            op_auipc: res = pc + {ins[31:12], 12'b0};
            op_jal: begin
                res = nxt;
                nxt = pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            op_jalr: begin
                res = nxt;
                nxt = (a + imm_i) & ~32'd1;
            end
            op_load: begin
                ea  = a + imm_i;
                res = mdata.exists(int'(ea[xlen-1:2])) ? mdata[int'(ea[xlen-1:2])] : '0;
                exp_q.push_back('{read: 1'b1, write: '0, addr: ea, wdata: '0});
            end
            op_store: begin
                ea = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                mdata[int'(ea[xlen-1:2])] = b;
                exp_q.push_back('{read: 1'b0, write: word_strobe, addr: ea, wdata: b});
                wr = 1'b0;
            end
            op_branch: begin
                case (ins[14:12])
                    3'b000:  take = (a == b);
                    3'b001:  take = (a != b);
                    3'b100:  take = ($signed(a) < $signed(b));
                    3'b101:  take = ($signed(a) >= $signed(b));
                    3'b110:  take = (a < b);
                    3'b111:  take = (a >= b);
                    default: take = 1'b0;
                endcase
                if (take) nxt = pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
                wr = 1'b0;
            end
            default: wr = 1'b0; // unknown opcode is a nop
        endcase
        if (wr && ins[11:7] != 5'd0) regs[ins[11:7]] = res;
        pc = nxt;
    endtask

    always @(posedge clk) begin
        dmem_req_t want;
        // rst_d set means the cycle just ended follows a reset edge
        if (rst_d === 1'b1) begin
            if (imem_req.read !== 1'b0 || dmem_req.read !== 1'b0 || dmem_req.write !== '0) begin
                $display("memory request active during reset or right after it at %0t", $time);
                errors++;
            end
        end
        if (rst) begin
            if (rst_d === 1'b0 && exp_q.size() != 0) begin
                $display("%0d data requests still outstanding at reset", exp_q.size());
                errors++;
            end
            reset_model();
        end else begin
            if (imem_req.read) begin
                check_word("imem_req.addr", imem_req.addr, pc);
                step_model();
                reqs_since_fetch = 0;
            end
            if (dmem_req.read || dmem_req.write != '0) begin
                reqs_since_fetch++;
                if (dmem_req.read && dmem_req.write != '0) begin
                    $display("data read and write in the same cycle at %0t", $time);
                    errors++;
                end
                if (reqs_since_fetch > 1) begin
                    $display("more than one data request for one instruction at %0t", $time);
                    errors++;
                end
                if (exp_q.size() == 0) begin
                    $display("data request that no instruction asked for at %0t", $time);
                    errors++;
                end else begin
                    want = exp_q.pop_front();
                    check_word("dmem_req.read", 32'(dmem_req.read), 32'(want.read));
                    check_word("dmem_req.write", 32'(dmem_req.write), 32'(want.write));
                    check_word("dmem_req.addr", dmem_req.addr, want.addr);
                    if (want.write != '0) check_word("dmem_req.wdata", dmem_req.wdata, want.wdata);
                end
            end
        end
        pending = exp_q.size();
        rst_d <= rst;
    end

endmodule

/* tb_rv_core.sv */
// testbench top: clock, reset, memory models, random programs, watchdog and DUT
`timescale 1ns/10ps

module tb_rv_core
    import rv_pkg::*;
();

    localparam int clk_period   = 40;
    localparam int reset_cycles = 8;
    localparam int num_progs    = 3;
    localparam int prog_len     = 200;
    localparam int dump_len     = num_regs;
    localparam int dump_at      = prog_len + 1; // first slot of the register dump
    localparam int end_slot     = dump_at + dump_len;
    localparam int imem_aw      = 9;
    localparam int dmem_aw      = 8;
    localparam int watchdog_ns  = num_progs * (prog_len + dump_len) * 5 * clk_period * 2;
    localparam logic [xlen-1:0] data_base = 32'h0001_0000;

    logic            clk;
    logic            rst;
    imem_req_t       imem_req;
    dmem_req_t       dmem_req;
    logic [xlen-1:0] instr_rdata = '0;
    logic [xlen-1:0] data_rdata  = '0;
    logic [xlen-1:0] imem [2**imem_aw];
    logic [xlen-1:0] dmem [2**dmem_aw];
    int              kinds [end_slot + 1];
    bit              can_land [end_slot + 1];
    logic [xlen-1:0] end_pc;
    int              errors;
    int              pending;
    int              tb_errors;

    rv_core rv_core_i (
        .clk         (clk),
        .rst         (rst),
        .imem_req    (imem_req),
        .instr_rdata (instr_rdata),
        .dmem_req    (dmem_req),
        .data_rdata  (data_rdata)
    );

    rv_checker checker_i (
        .clk      (clk),
        .rst      (rst),
        .imem_req (imem_req),
        .dmem_req (dmem_req),
        .errors   (errors),
        .pending  (pending)
    );

    function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd, input opcode_t opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input opcode_t opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] s_word(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], op_store};
    endfunction

    function automatic logic [31:0] b_word(input int off, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], op_branch};
    endfunction

    function automatic logic [31:0] u_word(input logic [19:0] imm, input logic [4:0] rd,
                                           input opcode_t opc);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] j_word(input int off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, op_jal};
    endfunction

    function automatic logic [4:0] pick_rd();
        logic [4:0] r;
        r = 5'($urandom);
        return (r == 5'd2) ? 5'd0 : r; // x2 holds the data base
    endfunction

    // forward target that skips the jalr half of a pair
    function automatic int fwd_offset(input int s);
        int t;
        t = s + 1 + int'($urandom % 8);
        if (t > dump_at) t = dump_at;
        if (!can_land[t]) t++;
        return (t - s) * 4;
    endfunction

    task automatic build_program();
        int          s;
        int          kind;
        logic [4:0]  rd;
        logic [4:0]  ra;
        logic [4:0]  rb;
        logic [2:0]  f3;
        logic        alt;
        logic [11:0] imm;
        s = 1;
        while (s < dump_at) begin
            kind = $urandom % 14;
            if (kind == 11 && s == dump_at - 1) kind = 0; // no room for auipc + jalr
            kinds[s]    = kind;
            can_land[s] = 1'b1;
            if (kind == 11) begin
                kinds[s + 1]    = 14;
                can_land[s + 1] = 1'b0;
                s += 2;
            end else begin
                s++;
            end
        end
        can_land[dump_at] = 1'b1;
        imem[0] = u_word(data_base[31:12], 5'd2, op_lui);
        for (s = 1; s < dump_at; s++) begin
            rd  = pick_rd();
            ra  = 5'($urandom);
            rb  = 5'($urandom);
            f3  = 3'($urandom);
            alt = 1'($urandom);
            case (kinds[s])
                0, 1, 2, 3: begin
                    imem[s] = r_word({1'b0, alt && (f3 == 3'b000 || f3 == 3'b101), 5'b0},
                                     rb, ra, f3, rd, op_reg);
                end
                4, 5, 6: begin
                    if (f3 == 3'b001 || f3 == 3'b101) begin
                        imm = {1'b0, alt && f3 == 3'b101, 5'b0, 5'($urandom)}; // shamt
                    end else begin
                        imm = 12'($urandom);
                    end
                    imem[s] = i_word(imm, ra, f3, rd, op_imm);
                end
                7:  imem[s] = u_word(20'($urandom), rd, op_lui);
                8:  imem[s] = u_word(20'($urandom), rd, op_auipc);
                9:  imem[s] = b_word(fwd_offset(s), rb, ra,
                                     (f3 == 3'b010 || f3 == 3'b011) ? f3 ^ 3'b100 : f3);
                10: imem[s] = j_word(fwd_offset(s), rd);
                11: begin
                    ra = 5'd3 + 5'($urandom % 29);
                    imem[s]     = u_word(20'd0, ra, op_auipc);
                    imem[s + 1] = i_word(12'd8 + 12'(alt), ra, 3'b000, rd, op_jalr); // odd offset too
                end
                // a small window so that loads often hit earlier stores
                12: imem[s] = i_word(12'($urandom % 16) << 2, 5'd2, 3'b010, rd, op_load);
                13: imem[s] = s_word(12'($urandom % 16) << 2, rb, 5'd2);
                default: ;
            endcase
        end
        for (int i = 0; i < dump_len; i++) begin
            imem[dump_at + i] = s_word(12'h300 + 12'(4 * i), 5'(i), 5'd2);
        end
        imem[end_slot] = j_word(0, 5'd0); // parks the core
        end_pc = 32'(end_slot * 4);
        for (int i = 0; i <= end_slot; i++) begin
            checker_i.load_word(i, imem[i]);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // one-cycle read latency on both ports
    always @(posedge clk) begin
        imem_req_t ireq;
        dmem_req_t dreq;
        logic      clear;
        ireq  = imem_req;
        dreq  = dmem_req;
        clear = rst;
        #1;
        if (ireq.read) instr_rdata = imem[ireq.addr[imem_aw+1:2]];
        if (clear) begin
            for (int i = 0; i < 2**dmem_aw; i++) dmem[i] = '0;
        end else begin
            if (dreq.read) data_rdata = dmem[dreq.addr[dmem_aw+1:2]];
            for (int b = 0; b < strb_w; b++) begin
                if (dreq.write[b]) dmem[dreq.addr[dmem_aw+1:2]][8*b +: 8] = dreq.wdata[8*b +: 8];
            end
        end
    end

    initial begin
        #(watchdog_ns);
        $display("watchdog expired after %0d ns, a program never reached its final jump",
                 watchdog_ns);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        tb_errors = 0;
        rst       = 1'b1;
        void'($urandom(32'h553374ad));
        for (int p = 0; p < num_progs; p++) begin
            rst = 1'b1;
            build_program();
            repeat (reset_cycles) @(posedge clk);
            #1;
            rst = 1'b0;
            while (!(imem_req.read && imem_req.addr == end_pc)) begin
                @(posedge clk);
                #1;
            end
            repeat (2) @(posedge clk);
            #1;
            if (pending != 0) begin
                $display("program %0d ended with %0d data requests never issued", p, pending);
                tb_errors++;
            end
        end
        $display("errors: checker %0d, testbench %0d", errors, tb_errors);
        if (errors == 0 && tb_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* rv_core.f */
rv_pkg.sv
rv_regfile.sv
rv_alu.sv
rv_decode.sv
rv_lsu.sv
rv_control.sv
rv_core.sv
rv_checker.sv
tb_rv_core.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_rv_core
FILELIST  ?= rv_core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Test FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "Test OK" $(LOG); then echo "simulation did not finish"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
